// File: all.f
common/dummy_pkg.sv
common/dummy_cfg_if.sv
hw/dummy_lfsr.sv
hw/dummy_csr_axil.sv
dummy_instr/dummy_instr_gen.sv
dummy_instr/dummy_instr_mux.sv
hw/dummy_obf_top.sv
test/dummy_obf_asserts.sv
test/tb_dummy_obf.sv

// File: Bender.yml
package:
  name: dummy_obf

sources:
  - common/dummy_pkg.sv
  - common/dummy_cfg_if.sv
  - hw/dummy_lfsr.sv
  - hw/dummy_csr_axil.sv
  - dummy_instr/dummy_instr_gen.sv
  - dummy_instr/dummy_instr_mux.sv
  - hw/dummy_obf_top.sv
  - target: test
    files:
      - test/dummy_obf_asserts.sv
      - test/tb_dummy_obf.sv

// File: test/tb_dummy_obf.sv
/*
 * Testbench for the obfuscation front end
 * Random fetch and decode traffic, register accesses and reference bookkeeping
 */
`timescale 1ns/1ns
`default_nettype none

module tb_dummy_obf;

  localparam int CLK_PERIOD  = 40;
  localparam int DIS_CYCLES  = 300;
  localparam int MASK_CYCLES = 400;
  // Rough length of one seed replay pass
  localparam int SEED_CYCLES = 250;
  // Twice the expected run length
  localparam int TIMEOUT_CYCLES = 2 * (DIS_CYCLES + 3 * MASK_CYCLES + 2 * SEED_CYCLES);
  localparam int REPLAY_LEN = 8;
  localparam dummy_pkg::instr_t     SEQ_BASE    = 32'h4000_0000;
  localparam dummy_pkg::axil_data_t TEST_SEED   = 32'h1357_9BDF;
  localparam dummy_pkg::axil_data_t REPLAY_SEED = 32'h5EED_0B5C;

  logic                  clk_i;
  logic                  rst_ni;
  dummy_pkg::axil_addr_t s_awaddr_i;
  logic                  s_awvalid_i;
  logic                  s_awready_o;
  dummy_pkg::axil_data_t s_wdata_i;
  dummy_pkg::axil_strb_t s_wstrb_i;
  logic                  s_wvalid_i;
  logic                  s_wready_o;
  dummy_pkg::axil_resp_t s_bresp_o;
  logic                  s_bvalid_o;
  logic                  s_bready_i;
  dummy_pkg::axil_addr_t s_araddr_i;
  logic                  s_arvalid_i;
  logic                  s_arready_o;
  dummy_pkg::axil_data_t s_rdata_o;
  dummy_pkg::axil_resp_t s_rresp_o;
  logic                  s_rvalid_o;
  logic                  s_rready_i;
  logic                  fetch_valid_i;
  dummy_pkg::instr_t     fetch_instr_i;
  logic                  fetch_ready_o;
  logic                  id_valid_o;
  dummy_pkg::instr_t     id_instr_o;
  logic                  id_dummy_o;
  logic                  id_ready_i;

  // Reference state
  int                    seed = 46171;
  int unsigned           cycle_count = 0;
  int unsigned           next_send = 0;
  int unsigned           exp_fetch = 0;
  int unsigned           dummy_count = 0;
  int unsigned           real_since = 0;
  logic                  fetch_taken = 1'b0;
  logic                  interval_armed = 1'b0;
  logic                  cur_en = 1'b0;
  dummy_pkg::mask_t      cur_mask = '0;
  int                    rec_mode = 0;
  int                    rec_mode_next = 0;
  int unsigned           replay_idx = 0;
  dummy_pkg::instr_t     rec_q[$];
  dummy_pkg::axil_data_t rd_data;

  dummy_obf_top UUT (.*);

  bind dummy_obf_top dummy_obf_asserts u_asserts (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_ready_i (fetch_ready_o),
    .id_valid_i    (id_valid_o),
    .id_ready_i    (id_ready_i),
    .id_instr_i    (id_instr_o),
    .id_dummy_i    (id_dummy_o),
    .bvalid_i      (s_bvalid_o),
    .bresp_i       (s_bresp_o),
    .rvalid_i      (s_rvalid_o),
    .rresp_i       (s_rresp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic stop_on_error();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic fail_run(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    stop_on_error();
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic require(input logic cond, input string what);
    assert (cond) else fail_run(what);
  endtask

  // Register mirrors take effect from the cycle after the handshake
  task automatic note_register_write(input dummy_pkg::axil_addr_t addr,
                                     input dummy_pkg::axil_data_t data);
    interval_armed = 1'b0;
    if (addr == dummy_pkg::REG_CTRL) begin
      cur_en   = data[0];
      cur_mask = data[3:1];
    end else if (addr == dummy_pkg::REG_SEED) begin
      rec_mode   = rec_mode_next;
      replay_idx = 0;
    end
  endtask

  task automatic note_dummy(input dummy_pkg::instr_t instr);
    dummy_count++;
    if (interval_armed) begin
      require(real_since <= int'(cur_mask) * 4 + 3,
              "too many real instructions between two dummies");
    end
    interval_armed = 1'b1;
    real_since     = 0;
    if (rec_mode == 1 && rec_q.size() < REPLAY_LEN) begin
      rec_q.push_back(instr);
    end else if (rec_mode == 2 && replay_idx < REPLAY_LEN) begin
      compare_value("id_instr_o of replayed dummy", instr, rec_q[replay_idx]);
      replay_idx++;
    end
  endtask

  task automatic axil_write(input dummy_pkg::axil_addr_t addr,
                            input dummy_pkg::axil_data_t data);
    @(negedge clk_i);
    s_awaddr_i  = addr;
    s_wdata_i   = data;
    s_wstrb_i   = 4'hF;
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    @(posedge clk_i);
    while (!s_awready_o) @(posedge clk_i);
    require(s_wready_o, "wready was not raised together with awready");
    @(negedge clk_i);
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    note_register_write(addr, data);
    require(s_bvalid_o, "write response did not follow the write handshake");
  endtask

  task automatic axil_read(input dummy_pkg::axil_addr_t addr,
                           output dummy_pkg::axil_data_t data);
    @(negedge clk_i);
    s_araddr_i  = addr;
    s_arvalid_i = 1'b1;
    @(posedge clk_i);
    while (!s_arready_o) @(posedge clk_i);
    @(negedge clk_i);
    s_arvalid_i = 1'b0;
    require(s_rvalid_o, "read data did not follow the address handshake");
    data = s_rdata_o;
  endtask

  // Random traffic where each raised fetch word is held until taken
  task automatic run_stream(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      if (!fetch_valid_i || fetch_taken) begin
        fetch_valid_i = ($random(seed) & 3) != 0;
        fetch_instr_i = SEQ_BASE + next_send;
      end
      id_ready_i = ($random(seed) & 3) != 0;
    end
  endtask

  task automatic drain_stream();
    @(negedge clk_i);
    id_ready_i = 1'b1;
    while (fetch_valid_i && !fetch_taken) begin
      @(negedge clk_i);
    end
    fetch_valid_i = 1'b0;
  endtask

  task automatic run_with_mask(input dummy_pkg::mask_t mask);
    dummy_pkg::axil_data_t ctrl;
    ctrl = {28'd0, mask, 1'b1};
    drain_stream();
    axil_write(dummy_pkg::REG_CTRL, ctrl);
    axil_read(dummy_pkg::REG_CTRL, rd_data);
    compare_value("REG_CTRL", rd_data, ctrl);
    run_stream(MASK_CYCLES);
  endtask

  // Decode side bookkeeping and stream checks
  always @(posedge clk_i) begin
    if (rst_ni) begin
      fetch_taken = fetch_valid_i && fetch_ready_o;
      if (fetch_taken) begin
        next_send++;
      end
      if (!cur_en) begin
        require(!id_dummy_o, "dummy presented while disabled");
        require(id_valid_o == fetch_valid_i, "id_valid_o does not follow fetch while disabled");
      end
      if (id_valid_o && id_ready_i) begin
        if (id_dummy_o) begin
          note_dummy(id_instr_o);
        end else begin
          compare_value("id_instr_o", id_instr_o, SEQ_BASE + exp_fetch);
          exp_fetch++;
          real_since++;
        end
      end
    end
  end

  always @(negedge clk_i) begin
    if (UUT.u_asserts.fail_count != 0) begin
      fail_run("a bound assertion on the DUT failed");
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run("timeout, the run did not complete in time");
    end
  end

  initial begin
    rst_ni        = 1'b0;
    s_awaddr_i    = '0;
    s_awvalid_i   = 1'b0;
    s_wdata_i     = '0;
    s_wstrb_i     = '0;
    s_wvalid_i    = 1'b0;
    s_bready_i    = 1'b1;
    s_araddr_i    = '0;
    s_arvalid_i   = 1'b0;
    s_rready_i    = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_instr_i = SEQ_BASE;
    id_ready_i    = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Disabled pass-through
    run_stream(DIS_CYCLES);
    drain_stream();
    axil_read(dummy_pkg::REG_COUNT, rd_data);
    compare_value("REG_COUNT", rd_data, 0);
    axil_write(dummy_pkg::REG_SEED, TEST_SEED);
    axil_read(dummy_pkg::REG_SEED, rd_data);
    compare_value("REG_SEED", rd_data, TEST_SEED);

    run_with_mask(3'd0);
    run_with_mask(3'd3);
    run_with_mask(3'd7);

    // Same seed twice gives the same dummy words
    drain_stream();
    axil_write(dummy_pkg::REG_CTRL, 32'h1);
    rec_mode_next = 1;
    axil_write(dummy_pkg::REG_SEED, REPLAY_SEED);
    while (rec_q.size() < REPLAY_LEN) run_stream(1);
    drain_stream();
    rec_mode_next = 2;
    axil_write(dummy_pkg::REG_SEED, REPLAY_SEED);
    while (replay_idx < REPLAY_LEN) run_stream(1);
    drain_stream();
    rec_mode = 0;

    axil_write(dummy_pkg::REG_CTRL, 32'h0);
    axil_read(dummy_pkg::REG_COUNT, rd_data);
    compare_value("REG_COUNT", rd_data, dummy_count);
    axil_read(dummy_pkg::REG_SEED, rd_data);
    compare_value("REG_SEED", rd_data, REPLAY_SEED);
    compare_value("forwarded fetch words", exp_fetch, next_send);

    @(negedge clk_i);
    if (UUT.u_asserts.fail_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      fail_run("a bound assertion on the DUT failed");
    end
  end

endmodule

`default_nettype wire

// File: test/dummy_obf_asserts.sv
/*
 * Concurrent checks on the decode stream, dummy encoding and AXI4-Lite responses
 */
`timescale 1ns/1ns
`default_nettype none

module dummy_obf_asserts (
  input wire logic                  clk_i,
  input wire logic                  rst_ni,
  input wire logic                  fetch_ready_i,
  input wire logic                  id_valid_i,
  input wire logic                  id_ready_i,
  input wire dummy_pkg::instr_t     id_instr_i,
  input wire logic                  id_dummy_i,
  input wire logic                  bvalid_i,
  input wire dummy_pkg::axil_resp_t bresp_i,
  input wire logic                  rvalid_i,
  input wire dummy_pkg::axil_resp_t rresp_i
);

  // Count of failed checks
  int unsigned fail_count = 0;

  // ADD, MUL, DIV and AND as {funct7, funct3}
  function automatic logic legal_funct(input dummy_pkg::instr_t instr);
    logic [9:0] f;
    f = {instr[31:25], instr[14:12]};
    return (f == 10'b0000000_000) || (f == 10'b0000001_000) ||
           (f == 10'b0000001_100) || (f == 10'b0000000_111);
  endfunction

  a_dummy_encoding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (id_valid_i && id_ready_i && id_dummy_i) |->
      (id_instr_i[6:0] == 7'h33 && id_instr_i[11:7] == 5'd0 && legal_funct(id_instr_i)))
    else begin
      $error("dummy word %h is not an R-type ADD, MUL, DIV or AND to x0", id_instr_i);
      fail_count++;
    end

  // Decode stalled, so the presented word must not move
  a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (id_valid_i && !id_ready_i) |=> ($stable(id_instr_i) && $stable(id_dummy_i)))
    else begin
      $error("decode word or dummy flag changed while decode was stalled");
      fail_count++;
    end

  a_fetch_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    id_dummy_i |-> !fetch_ready_i)
    else begin
      $error("fetch_ready_o high while a dummy is presented");
      fail_count++;
    end

  a_bresp_okay: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bvalid_i |-> (bresp_i == 2'b00))
    else begin
      $error("write response %b is not OKAY", bresp_i);
      fail_count++;
    end

  a_rresp_okay: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> (rresp_i == 2'b00))
    else begin
      $error("read response %b is not OKAY", rresp_i);
      fail_count++;
    end

endmodule

`default_nettype wire

// File: hw/dummy_obf_top.sv
/*
 * Instruction obfuscation front end between fetch and decode
 * Register block, dummy generator and stream mux
 */
`timescale 1ns/1ns
`default_nettype none

module dummy_obf_top (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire dummy_pkg::axil_addr_t s_awaddr_i,
  input  wire logic                  s_awvalid_i,
  output      logic                  s_awready_o,
  input  wire dummy_pkg::axil_data_t s_wdata_i,
  input  wire dummy_pkg::axil_strb_t s_wstrb_i,
  input  wire logic                  s_wvalid_i,
  output      logic                  s_wready_o,
  output      dummy_pkg::axil_resp_t s_bresp_o,
  output      logic                  s_bvalid_o,
  input  wire logic                  s_bready_i,
  input  wire dummy_pkg::axil_addr_t s_araddr_i,
  input  wire logic                  s_arvalid_i,
  output      logic                  s_arready_o,
  output      dummy_pkg::axil_data_t s_rdata_o,
  output      dummy_pkg::axil_resp_t s_rresp_o,
  output      logic                  s_rvalid_o,
  input  wire logic                  s_rready_i,
  input  wire logic                  fetch_valid_i,
  input  wire dummy_pkg::instr_t     fetch_instr_i,
  output      logic                  fetch_ready_o,
  output      logic                  id_valid_o,
  output      dummy_pkg::instr_t     id_instr_o,
  output      logic                  id_dummy_o,
  input  wire logic                  id_ready_i
);

  logic              insert;
  dummy_pkg::instr_t dummy_instr;

  dummy_cfg_if cfg_if ();

  dummy_csr_axil u_csr (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wstrb_i   (s_wstrb_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .cfg         (cfg_if.csr)
  );

  dummy_instr_gen u_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg           (cfg_if.gen),
    .fetch_valid_i (fetch_valid_i),
    .id_ready_i    (id_ready_i),
    .insert_o      (insert),
    .dummy_instr_o (dummy_instr)
  );

  // Zero-latency path from fetch to decode
  dummy_instr_mux u_mux (
    .fetch_valid_i (fetch_valid_i),
    .fetch_instr_i (fetch_instr_i),
    .fetch_ready_o (fetch_ready_o),
    .insert_i      (insert),
    .dummy_instr_i (dummy_instr),
    .id_ready_i    (id_ready_i),
    .id_valid_o    (id_valid_o),
    .id_instr_o    (id_instr_o),
    .id_dummy_o    (id_dummy_o)
  );

endmodule

`default_nettype wire

// File: dummy_instr/dummy_instr_mux.sv
/*
 * Merges dummy instructions into the fetch-to-decode stream
 * Fetch is stalled while a dummy is presented
 */
`timescale 1ns/1ns
`default_nettype none

module dummy_instr_mux (
  input  wire logic              fetch_valid_i,
  input  wire dummy_pkg::instr_t fetch_instr_i,
  output      logic              fetch_ready_o,
  input  wire logic              insert_i,
  input  wire dummy_pkg::instr_t dummy_instr_i,
  input  wire logic              id_ready_i,
  output      logic              id_valid_o,
  output      dummy_pkg::instr_t id_instr_o,
  output      logic              id_dummy_o
);

  always_comb begin
    if (insert_i) begin
      // Dummy always valid, fetched word waits
      id_valid_o    = 1'b1;
      id_instr_o    = dummy_instr_i;
      id_dummy_o    = 1'b1;
      fetch_ready_o = 1'b0;
    end else begin
      id_valid_o    = fetch_valid_i;
      id_instr_o    = fetch_instr_i;
      id_dummy_o    = 1'b0;
      fetch_ready_o = id_ready_i;
    end
  end

endmodule

`default_nettype wire

// File: dummy_instr/dummy_instr_gen.sv
/*
 * Dummy instruction generator: pseudo-random interval counter,
 * threshold compare and R-type dummy encoding
 */
`timescale 1ns/1ns
`default_nettype none

module dummy_instr_gen (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  dummy_cfg_if.gen               cfg,
  input  wire logic              fetch_valid_i,
  input  wire logic              id_ready_i,
  output      logic              insert_o,
  output      dummy_pkg::instr_t dummy_instr_o
);

  dummy_pkg::lfsr_state_t          lfsr_state;
  dummy_pkg::dummy_cnt_t           lfsr_cnt;
  dummy_pkg::dummy_cnt_t           cnt_thresh;
  dummy_pkg::dummy_cnt_t           cnt_d;
  dummy_pkg::dummy_cnt_t           cnt_q;
  logic [dummy_pkg::OP_W-1:0]      op_a;
  logic [dummy_pkg::OP_W-1:0]      op_b;
  dummy_pkg::dummy_instr_e         instr_type;
  logic                            cnt_en;
  logic                            insert;
  logic                            dummy_taken;
  logic [6:0]                      funct7;
  logic [2:0]                      funct3;

  // LFSR advances once per accepted dummy
  dummy_lfsr u_lfsr (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .seed_valid_i (cfg.seed_valid),
    .seed_i       (cfg.seed),
    .lfsr_en_i    (dummy_taken),
    .state_o      (lfsr_state)
  );

  // Low LFSR bits, from bit 0: count, op_a, op_b, type
  assign lfsr_cnt   = lfsr_state[dummy_pkg::CNT_W-1:0];
  assign op_a       = lfsr_state[dummy_pkg::CNT_W +: dummy_pkg::OP_W];
  assign op_b       = lfsr_state[dummy_pkg::CNT_W+dummy_pkg::OP_W +: dummy_pkg::OP_W];
  assign instr_type = dummy_pkg::dummy_instr_e'(
      lfsr_state[dummy_pkg::CNT_W+2*dummy_pkg::OP_W +: $bits(dummy_pkg::dummy_instr_e)]);

  // Mask shortens the longest interval, low two bits always free
  assign cnt_thresh = lfsr_cnt &
                      {cfg.mask, {(dummy_pkg::CNT_W-dummy_pkg::MASK_W){1'b1}}};

  assign insert      = cfg.en & (cnt_q == cnt_thresh);
  assign dummy_taken = insert & id_ready_i;

  // Count real and dummy instructions taken by decode
  assign cnt_en = cfg.en & id_ready_i & (fetch_valid_i | insert);
  assign cnt_d  = insert ? '0 : cnt_q + dummy_pkg::dummy_cnt_t'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cfg.seed_valid) begin
      // New seed restarts the interval
      cnt_q <= '0;
    end else if (cnt_en) begin
      cnt_q <= cnt_d;
    end
  end

  always_comb begin
    case (instr_type)
      dummy_pkg::DUMMY_ADD: begin
        funct7 = 7'b000_0000;
        funct3 = 3'b000;
      end
      dummy_pkg::DUMMY_MUL: begin
        funct7 = 7'b000_0001;
        funct3 = 3'b000;
      end
      dummy_pkg::DUMMY_DIV: begin
        funct7 = 7'b000_0001;
        funct3 = 3'b100;
      end
      dummy_pkg::DUMMY_AND: begin
        funct7 = 7'b000_0000;
        funct3 = 3'b111;
      end
      default: begin
        funct7 = 7'b000_0000;
        funct3 = 3'b000;
      end
    endcase
  end

  // funct7 | rs2 | rs1 | funct3 | rd=x0 | opcode
  assign dummy_instr_o = {funct7, op_b, op_a, funct3, {dummy_pkg::OP_W{1'b0}},
                          dummy_pkg::OPCODE_OP};

  assign insert_o        = insert;
  assign cfg.dummy_taken = dummy_taken;

endmodule

`default_nettype wire

// File: hw/dummy_csr_axil.sv
/*
 * AXI4-Lite register block for the dummy instruction generator
 * Holds enable, interval mask, LFSR seed and the inserted-dummy count
 */
`timescale 1ns/1ns
`default_nettype none

module dummy_csr_axil (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire dummy_pkg::axil_addr_t s_awaddr_i,
  input  wire logic                  s_awvalid_i,
  output      logic                  s_awready_o,
  input  wire dummy_pkg::axil_data_t s_wdata_i,
  input  wire dummy_pkg::axil_strb_t s_wstrb_i,
  input  wire logic                  s_wvalid_i,
  output      logic                  s_wready_o,
  output      dummy_pkg::axil_resp_t s_bresp_o,
  output      logic                  s_bvalid_o,
  input  wire logic                  s_bready_i,
  input  wire dummy_pkg::axil_addr_t s_araddr_i,
  input  wire logic                  s_arvalid_i,
  output      logic                  s_arready_o,
  output      dummy_pkg::axil_data_t s_rdata_o,
  output      dummy_pkg::axil_resp_t s_rresp_o,
  output      logic                  s_rvalid_o,
  input  wire logic                  s_rready_i,
  dummy_cfg_if.csr                   cfg
);

  logic                   wr_hs;
  logic                   rd_hs;
  logic                   ctrl_wr;
  logic                   seed_wr;
  logic                   bvalid_q;
  logic                   rvalid_q;
  dummy_pkg::axil_data_t  rdata_d;
  dummy_pkg::axil_data_t  rdata_q;
  logic                   en_q;
  dummy_pkg::mask_t       mask_q;
  dummy_pkg::lfsr_state_t seed_q;
  dummy_pkg::lfsr_state_t seed_new;
  dummy_pkg::axil_data_t  count_q;

  // Byte-lane merge of write data into a register value
  function automatic dummy_pkg::axil_data_t merge_strb(
    input dummy_pkg::axil_data_t old_val,
    input dummy_pkg::axil_data_t new_val,
    input dummy_pkg::axil_strb_t strb
  );
    dummy_pkg::axil_data_t res;
    res = old_val;
    for (int i = 0; i < $bits(strb); i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Address and data taken together, only with no response pending
  assign wr_hs       = s_awvalid_i & s_wvalid_i & ~bvalid_q;
  assign s_awready_o = wr_hs;
  assign s_wready_o  = wr_hs;

  assign ctrl_wr  = wr_hs & (s_awaddr_i == dummy_pkg::REG_CTRL) & s_wstrb_i[0];
  assign seed_wr  = wr_hs & (s_awaddr_i == dummy_pkg::REG_SEED) & (|s_wstrb_i);
  assign seed_new = merge_strb(seed_q, s_wdata_i, s_wstrb_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_q <= 1'b0;
      en_q     <= 1'b0;
      mask_q   <= '0;
      seed_q   <= dummy_pkg::LFSR_DEFAULT_SEED;
    end else begin
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (s_bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (ctrl_wr) begin
        en_q   <= s_wdata_i[0];
        mask_q <= s_wdata_i[dummy_pkg::MASK_W:1];
      end
      if (seed_wr) begin
        seed_q <= seed_new;
      end
    end
  end

  // Wrapping count of accepted dummies
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (cfg.dummy_taken) begin
      count_q <= count_q + dummy_pkg::axil_data_t'(1);
    end
  end

  // Read path, unmapped addresses return zero
  assign s_arready_o = ~rvalid_q;
  assign rd_hs       = s_arvalid_i & ~rvalid_q;

  always_comb begin
    rdata_d = '0;
    case (s_araddr_i)
      dummy_pkg::REG_CTRL:  rdata_d[dummy_pkg::MASK_W:0] = {mask_q, en_q};
      dummy_pkg::REG_SEED:  rdata_d = seed_q;
      dummy_pkg::REG_COUNT: rdata_d = count_q;
      default:              rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else if (rd_hs) begin
      rvalid_q <= 1'b1;
    end else if (s_rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_hs) begin
      rdata_q <= rdata_d;
    end
  end

  assign s_bvalid_o = bvalid_q;
  assign s_bresp_o  = dummy_pkg::AXIL_RESP_OKAY;
  assign s_rvalid_o = rvalid_q;
  assign s_rdata_o  = rdata_q;
  assign s_rresp_o  = dummy_pkg::AXIL_RESP_OKAY;

  // Seed goes to the LFSR in the same cycle as the handshake
  assign cfg.en         = en_q;
  assign cfg.mask       = mask_q;
  assign cfg.seed_valid = seed_wr;
  assign cfg.seed       = seed_new;

endmodule

`default_nettype wire

// File: hw/dummy_lfsr.sv
/*
 * Seedable 32-bit Galois LFSR, one step per enable
 */
`timescale 1ns/1ns
`default_nettype none

module dummy_lfsr (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   seed_valid_i,
  input  wire dummy_pkg::lfsr_state_t seed_i,
  input  wire logic                   lfsr_en_i,
  output      dummy_pkg::lfsr_state_t state_o
);

  dummy_pkg::lfsr_state_t state_q;
  dummy_pkg::lfsr_state_t state_step;
  dummy_pkg::lfsr_state_t seed_safe;

  // All-zero state would never leave zero
  assign seed_safe = (seed_i == '0) ? dummy_pkg::LFSR_DEFAULT_SEED : seed_i;

  // Shift right, fold taps in when the low bit drops out
  always_comb begin
    state_step = state_q >> 1;
    if (state_q[0]) begin
      state_step = state_step ^ dummy_pkg::LFSR_POLY;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= dummy_pkg::LFSR_DEFAULT_SEED;
    end else if (seed_valid_i) begin
      state_q <= seed_safe;
    end else if (lfsr_en_i) begin
      state_q <= state_step;
    end
  end

  assign state_o = state_q;

endmodule

`default_nettype wire

// File: common/dummy_cfg_if.sv
/*
 * Configuration bundle from the register block to the dummy generator,
 * with accepted-dummy events flowing back for counting
 */
`timescale 1ns/1ns
`default_nettype none

interface dummy_cfg_if;

  logic                   en;
  dummy_pkg::mask_t       mask;
  logic                   seed_valid;
  dummy_pkg::lfsr_state_t seed;
  // One pulse per dummy accepted by decode
  logic                   dummy_taken;

  modport csr (
    output en,
    output mask,
    output seed_valid,
    output seed,
    input  dummy_taken
  );

  modport gen (
    input  en,
    input  mask,
    input  seed_valid,
    input  seed,
    output dummy_taken
  );

endinterface

`default_nettype wire

// File: common/dummy_pkg.sv
/*
 * Dummy instruction obfuscation package
 * Shared widths, types, register map and LFSR constants
 */
`default_nettype none

package dummy_pkg;

  // Instruction and field widths
  localparam int unsigned INSTR_W = 32;
  localparam int unsigned CNT_W   = 5;
  localparam int unsigned OP_W    = 5;
  localparam int unsigned MASK_W  = 3;
  localparam int unsigned LFSR_W  = 32;

  typedef logic [INSTR_W-1:0] instr_t;
  typedef logic [LFSR_W-1:0]  lfsr_state_t;
  typedef logic [CNT_W-1:0]   dummy_cnt_t;
  typedef logic [MASK_W-1:0]  mask_t;

  // Dummy instruction kinds, all R-type writing x0
  typedef enum logic [1:0] {
    DUMMY_ADD = 2'b00,
    DUMMY_MUL = 2'b01,
    DUMMY_DIV = 2'b10,
    DUMMY_AND = 2'b11
  } dummy_instr_e;

  localparam logic [6:0] OPCODE_OP = 7'h33;

  // Galois taps for x^32 + x^22 + x^2 + x + 1
  localparam lfsr_state_t LFSR_POLY         = 32'h8020_0003;
  localparam lfsr_state_t LFSR_DEFAULT_SEED = 32'hACE1_5A3D;

  // AXI4-Lite widths
  localparam int unsigned AXIL_ADDR_W = 4;
  localparam int unsigned AXIL_DATA_W = 32;

  typedef logic [AXIL_ADDR_W-1:0]   axil_addr_t;
  typedef logic [AXIL_DATA_W-1:0]   axil_data_t;
  typedef logic [AXIL_DATA_W/8-1:0] axil_strb_t;
  typedef logic [1:0]               axil_resp_t;

  localparam axil_resp_t AXIL_RESP_OKAY = 2'b00;

  // Register map
  localparam axil_addr_t REG_CTRL  = 4'h0;
  localparam axil_addr_t REG_SEED  = 4'h4;
  localparam axil_addr_t REG_COUNT = 4'h8;

endpackage

`default_nettype wire
